// ==== src/vexec_pkg.sv ====
// Vector execute package with element widths, unit and op encodings, and stage structs
package vexec_pkg;

  localparam int WORD_W = 32;
  localparam int VOFF_W = 5;
  localparam int VLEN_W = 6;
  localparam int REG_W  = 5;

  // Byte step between 32-bit elements on a unit-stride access
  localparam logic [WORD_W-1:0] STRIDE_UNIT = 32'd4;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [VOFF_W-1:0] voff_t;
  typedef logic [VLEN_W-1:0] vlen_t;
  typedef logic [REG_W-1:0]  regsel_t;

  // MIN and MAX compare signed, shifts take the low 5 bits of vs1
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    MIN,
    MAX
  } aluop_t;

  typedef enum logic [1:0] {
    FU_ALU,
    FU_MASK,
    FU_LS,
    FU_CFG
  } fu_t;

  typedef enum logic [1:0] {
    SRC_V,
    SRC_I,
    SRC_X
  } src_t;

  // Per-lane control, same for both lanes
  typedef struct packed {
    fu_t    fu;
    aluop_t aluop;
  } lane_ctrl_t;

  // Decoded instruction, one element pair
  typedef struct packed {
    fu_t     fu;
    aluop_t  aluop;
    src_t    rs1_src;
    src_t    rs2_src;
    word_t   vs1_lane0;
    word_t   vs1_lane1;
    word_t   vs2_lane0;
    word_t   vs2_lane1;
    word_t   imm;
    word_t   xs1;
    word_t   xs2;
    logic    stride_type;
    word_t   stride_val;
    logic    mask0;
    logic    mask1;
    logic    vm;
    voff_t   woffset0;
    voff_t   woffset1;
    logic [1:0] wen;
    logic    load;
    logic    store;
    word_t   storedata0;
    word_t   storedata1;
    regsel_t vd;
    vlen_t   vl;
    logic    rd_wen;
    regsel_t rd_sel;
  } ex_in_t;

  // Execute to memory latch contents
  typedef struct packed {
    logic    load;
    logic    store;
    word_t   storedata0;
    word_t   storedata1;
    word_t   aluresult0;
    word_t   aluresult1;
    logic [1:0] wen;
    voff_t   woffset0;
    voff_t   woffset1;
    regsel_t vd;
    vlen_t   vl;
    logic    rd_wen;
    regsel_t rd_sel;
    word_t   rd_data;
  } ex_out_t;

endpackage

// ==== src/vector_lane.sv ====
// Vector lane with integer ALU, iota result select and load/store address step
`timescale 1ns/1ps

module vector_lane (
  input  vexec_pkg::lane_ctrl_t ctrl,
  input  vexec_pkg::word_t      vs1,
  input  vexec_pkg::word_t      vs2,
  input  vexec_pkg::word_t      iota_res,
  input  vexec_pkg::word_t      addr_in,
  input  vexec_pkg::word_t      stride,
  output vexec_pkg::word_t      result,
  output vexec_pkg::word_t      addr_next
);

  import vexec_pkg::*;

  word_t      alu_out;
  logic [4:0] shamt;
  logic       vs2_lt_vs1;

  // Only the low 5 bits count for 32-bit elements
  assign shamt = vs1[4:0];

  assign vs2_lt_vs1 = $signed(vs2) < $signed(vs1);

  // vs2 is the first operand, as in vsub.vv vd, vs2, vs1
  always_comb begin
    case (ctrl.aluop)
      ADD: begin
        alu_out = vs2 + vs1;
      end
      SUB: begin
        alu_out = vs2 - vs1;
      end
      AND: begin
        alu_out = vs2 & vs1;
      end
      OR: begin
        alu_out = vs2 | vs1;
      end
      XOR: begin
        alu_out = vs2 ^ vs1;
      end
      SLL: begin
        alu_out = vs2 << shamt;
      end
      SRL: begin
        alu_out = vs2 >> shamt;
      end
      MIN: begin
        alu_out = vs2_lt_vs1 ? vs2 : vs1;
      end
      MAX: begin
        alu_out = vs2_lt_vs1 ? vs1 : vs2;
      end
      default: begin
        alu_out = '0;
      end
    endcase
  end

  // Result by functional unit
  always_comb begin
    case (ctrl.fu)
      FU_ALU: begin
        result = alu_out;
      end
      FU_MASK: begin
        result = iota_res;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // Next element address, chained into the following lane
  assign addr_next = addr_in + stride;

endmodule

// ==== src/iota_logic.sv ====
// Iota unit keeping a running count of set mask bits across element pairs
`timescale 1ns/1ps

module iota_logic (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             iota,
  input  logic             stall,
  input  logic [1:0]       mask_bits,
  input  vexec_pkg::voff_t woffset0,
  output vexec_pkg::word_t res0,
  output vexec_pkg::word_t res1
);

  import vexec_pkg::*;

  word_t count;
  word_t base;
  word_t bit0;
  word_t bit1;

  assign bit0 = {{(WORD_W-1){1'b0}}, mask_bits[0]};
  assign bit1 = {{(WORD_W-1){1'b0}}, mask_bits[1]};

  // First pair of a vector starts the prefix count over
  assign base = (woffset0 == '0) ? '0 : count;

  assign res0 = base;
  assign res1 = base + bit0;

  // Count only advances when the pair is actually taken
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count <= '0;
    end else if (!stall && iota) begin
      count <= base + bit0 + bit1;
    end
  end

endmodule

// ==== src/vexec_execute_stage.sv ====
// Vector execute stage with operand select, two lanes, iota unit and execute/memory latch
`timescale 1ns/1ps

module vexec_execute_stage (
  input  logic               CLK,
  input  logic               nRST,
  input  vexec_pkg::ex_in_t  ex_in,
  input  logic               stall,
  input  logic               flush,
  output vexec_pkg::ex_out_t ex_out
);

  import vexec_pkg::*;

  lane_ctrl_t lane_ctrl;
  word_t      vs1_l0;
  word_t      vs1_l1;
  word_t      vs2_l0;
  word_t      vs2_l1;
  word_t      stride;
  word_t      addr_buffer;
  word_t      addr_in0;
  word_t      addr_next0;
  word_t      addr_next1;
  word_t      result0;
  word_t      result1;
  word_t      iota_res0;
  word_t      iota_res1;
  logic       iota_en;
  logic       ls;
  logic       is_cfg;
  ex_out_t    ex_next;

  assign lane_ctrl.fu    = ex_in.fu;
  assign lane_ctrl.aluop = ex_in.aluop;

  // rs1 operand select
  always_comb begin
    case (ex_in.rs1_src)
      SRC_V: begin
        vs1_l0 = ex_in.vs1_lane0;
        vs1_l1 = ex_in.vs1_lane1;
      end
      SRC_I: begin
        vs1_l0 = ex_in.imm;
        vs1_l1 = ex_in.imm;
      end
      SRC_X: begin
        vs1_l0 = ex_in.xs1;
        vs1_l1 = ex_in.xs1;
      end
      default: begin
        vs1_l0 = '0;
        vs1_l1 = '0;
      end
    endcase
  end

  // rs2 operand select
  always_comb begin
    case (ex_in.rs2_src)
      SRC_V: begin
        vs2_l0 = ex_in.vs2_lane0;
        vs2_l1 = ex_in.vs2_lane1;
      end
      SRC_I: begin
        vs2_l0 = ex_in.imm;
        vs2_l1 = ex_in.imm;
      end
      SRC_X: begin
        vs2_l0 = ex_in.xs2;
        vs2_l1 = ex_in.xs2;
      end
      default: begin
        vs2_l0 = '0;
        vs2_l1 = '0;
      end
    endcase
  end

  // Strided access uses the scalar stride, otherwise one word per element
  assign stride = ex_in.stride_type ? ex_in.stride_val : STRIDE_UNIT;

  // Element 0 starts at the base, later pairs continue from the buffer
  assign addr_in0 = (ex_in.woffset0 == '0) ? ex_in.xs1 : addr_buffer;

  assign iota_en = (ex_in.fu == FU_MASK);

  vector_lane u_lane0 (
    .ctrl      (lane_ctrl),
    .vs1       (vs1_l0),
    .vs2       (vs2_l0),
    .iota_res  (iota_res0),
    .addr_in   (addr_in0),
    .stride    (stride),
    .result    (result0),
    .addr_next (addr_next0)
  );

  vector_lane u_lane1 (
    .ctrl      (lane_ctrl),
    .vs1       (vs1_l1),
    .vs2       (vs2_l1),
    .iota_res  (iota_res1),
    .addr_in   (addr_next0),
    .stride    (stride),
    .result    (result1),
    .addr_next (addr_next1)
  );

  // Flush folded in so the count tracks what the latch captures
  iota_logic u_iota (
    .CLK       (CLK),
    .nRST      (nRST),
    .iota      (iota_en),
    .stall     (stall | flush),
    .mask_bits ({ex_in.mask1, ex_in.mask0}),
    .woffset0  (ex_in.woffset0),
    .res0      (iota_res0),
    .res1      (iota_res1)
  );

  // Address of the next element pair
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      addr_buffer <= '0;
    end else if (!stall) begin
      addr_buffer <= addr_next1;
    end
  end

  assign ls     = ex_in.load | ex_in.store;
  assign is_cfg = (ex_in.fu == FU_CFG);

  // Next latch contents
  always_comb begin
    ex_next.load       = ex_in.load;
    ex_next.store      = ex_in.store;
    ex_next.storedata0 = ex_in.storedata0;
    ex_next.storedata1 = ex_in.storedata1;
    ex_next.aluresult0 = ls ? addr_in0 : result0;
    ex_next.aluresult1 = ls ? addr_next0 : result1;
    ex_next.wen[0]     = ex_in.wen[0] & (ex_in.vm | ex_in.mask0);
    ex_next.wen[1]     = ex_in.wen[1] & (ex_in.vm | ex_in.mask1);
    ex_next.woffset0   = ex_in.woffset0;
    ex_next.woffset1   = ex_in.woffset1;
    ex_next.vd         = ex_in.vd;
    ex_next.vl         = ex_in.vl;
    ex_next.rd_wen     = ex_in.rd_wen | is_cfg;
    ex_next.rd_sel     = ex_in.rd_sel;
    // Config ops write the new vector length back to the scalar file
    ex_next.rd_data    = is_cfg ? {{(WORD_W-VLEN_W){1'b0}}, ex_in.vl} : result0;
  end

  // Execute/memory latch, flush wins over stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_out <= '0;
    end else if (flush) begin
      ex_out <= '0;
    end else if (!stall) begin
      ex_out <= ex_next;
    end
  end

endmodule

// ==== verification/vexec_vectors.svh ====
// Directed stimulus rows for the vector execute stage with literal expected latch contents
`ifndef VEXEC_VECTORS_SVH
`define VEXEC_VECTORS_SVH

// Load or store pair, base in xs1, both elements enabled
function automatic ex_in_t ls_in(logic st, logic strided, word_t base, voff_t woff);
  ex_in_t r;
  r = '0;
  r.fu = FU_LS;
  r.load = ~st;
  r.store = st;
  r.stride_type = strided;
  // Ignored unless stride_type is set
  r.stride_val = 32'd12;
  r.xs1 = base;
  r.woffset0 = woff;
  r.woffset1 = woff + 5'd1;
  r.wen = 2'b11;
  r.vm = 1'b1;
  r.storedata0 = {16'hcafe, 11'd0, woff};
  return r;
endfunction

// Mask pair for iota, given as mask0 then mask1
function automatic ex_in_t iota_in(logic m0, logic m1, voff_t woff);
  ex_in_t r;
  r = '0;
  r.fu = FU_MASK;
  r.mask0 = m0;
  r.mask1 = m1;
  r.woffset0 = woff;
  r.woffset1 = woff + 5'd1;
  r.wen = 2'b11;
  return r;
endfunction

// Latch contents for a load/store or iota row
function automatic ex_out_t lit_out(ex_in_t r, word_t a0, word_t a1, logic [1:0] wen);
  ex_out_t e;
  e = '0;
  e.load = r.load;
  e.store = r.store;
  e.storedata0 = r.storedata0;
  e.aluresult0 = a0;
  e.aluresult1 = a1;
  e.wen = wen;
  e.woffset0 = r.woffset0;
  e.woffset1 = r.woffset1;
  e.rd_data = (r.fu == FU_MASK) ? a0 : '0;
  return e;
endfunction

task automatic load_directed_rows();
  ex_in_t  r;
  ex_out_t e;
  ex_out_t held;
  // Unit stride from 0x1000, stalled once before the last pair
  r = ls_in(1'b0, 1'b0, 32'h1000, 5'd0);
  add_row("ld_unit_off0", r, 1'b0, 1'b0, 1'b0, lit_out(r, 32'h1000, 32'h1004, 2'b11));
  r = ls_in(1'b0, 1'b0, 32'h1000, 5'd2);
  held = lit_out(r, 32'h1008, 32'h100c, 2'b11);
  add_row("ld_unit_off2", r, 1'b0, 1'b0, 1'b0, held);
  r = ls_in(1'b0, 1'b0, 32'h1000, 5'd4);
  add_row("ld_unit_stall", r, 1'b1, 1'b0, 1'b0, held);
  add_row("ld_unit_off4", r, 1'b0, 1'b0, 1'b0, lit_out(r, 32'h1010, 32'h1014, 2'b11));
  // 12 byte stride, offset zero restarts at the new base
  r = ls_in(1'b1, 1'b1, 32'h2000, 5'd0);
  add_row("st_stride_off0", r, 1'b0, 1'b0, 1'b0, lit_out(r, 32'h2000, 32'h200c, 2'b11));
  r = ls_in(1'b1, 1'b1, 32'h2000, 5'd2);
  add_row("st_stride_off2", r, 1'b0, 1'b0, 1'b0, lit_out(r, 32'h2018, 32'h2024, 2'b11));
  r = ls_in(1'b1, 1'b1, 32'h2000, 5'd4);
  // Flush under stall clears a full latch and keeps the address
  add_row("flush_over_stall", r, 1'b1, 1'b1, 1'b0, '0);
  add_row("st_stride_off4", r, 1'b0, 1'b0, 1'b0, lit_out(r, 32'h2030, 32'h203c, 2'b11));
  add_row("flush", r, 1'b0, 1'b1, 1'b0, '0);
  add_row("stall_after_flush", r, 1'b1, 1'b0, 1'b0, '0);
  // Iota prefix counts, stall must not advance the count
  r = iota_in(1'b1, 1'b1, 5'd0);
  add_row("iota_off0", r, 1'b0, 1'b0, 1'b0, lit_out(r, 32'd0, 32'd1, 2'b11));
  r = iota_in(1'b0, 1'b1, 5'd2);
  held = lit_out(r, 32'd2, 32'd2, 2'b10);
  add_row("iota_off2", r, 1'b0, 1'b0, 1'b0, held);
  r = iota_in(1'b1, 1'b0, 5'd4);
  add_row("iota_stall", r, 1'b1, 1'b0, 1'b0, held);
  add_row("iota_off4", r, 1'b0, 1'b0, 1'b0, lit_out(r, 32'd3, 32'd4, 2'b01));
  r = iota_in(1'b1, 1'b1, 5'd0);
  add_row("iota_restart", r, 1'b0, 1'b0, 1'b0, lit_out(r, 32'd0, 32'd1, 2'b11));
  // Write enable masking, checked against the rule model
  r = iota_in(1'b1, 1'b0, 5'd0);
  r.fu = FU_ALU;
  add_row("mask_vm_clear", r, 1'b0, 1'b0, 1'b1, '0);
  r.vm = 1'b1;
  r.mask0 = 1'b0;
  add_row("mask_vm_set", r, 1'b0, 1'b0, 1'b1, '0);
  r.vm = 1'b0;
  r.wen = 2'b10;
  r.mask0 = 1'b1;
  r.mask1 = 1'b1;
  add_row("mask_wen_partial", r, 1'b0, 1'b0, 1'b1, '0);
  // Config writes vl back to the scalar file
  r = '0;
  r.fu = FU_CFG;
  r.vl = 6'd32;
  r.rd_sel = 5'd7;
  e = '0;
  e.vl = 6'd32;
  e.rd_sel = 5'd7;
  e.rd_wen = 1'b1;
  e.rd_data = 32'd32;
  add_row("cfg_vl", r, 1'b0, 1'b0, 1'b0, e);
endtask

`endif

// ==== verification/vexec_tb.sv ====
// Testbench for the vector execute stage, running a table of random and directed rows
`timescale 1ns/1ps

module vexec_tb;

  import vexec_pkg::*;

  logic    CLK;
  logic    nRST;
  logic    stall;
  logic    flush;
  ex_in_t  ex_in;
  ex_out_t ex_out;

  string   row_name[$];
  ex_in_t  row_in[$];
  logic    row_stall[$];
  logic    row_flush[$];
  logic    row_model[$];
  ex_out_t row_exp[$];

  int pass_count = 0;
  int fail_count = 0;
  int cycle_count = 0;
  int timeout_limit = 0;

  vexec_execute_stage u_vexec_execute_stage (
    .CLK    (CLK),
    .nRST   (nRST),
    .ex_in  (ex_in),
    .stall  (stall),
    .flush  (flush),
    .ex_out (ex_out)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (timeout_limit > 0 && cycle_count > timeout_limit) begin
      $display("Run timed out after %0d cycles before the table was done", cycle_count);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic add_row(string name, ex_in_t in, logic st, logic fl, logic use_model,
                         ex_out_t exp);
    row_name.push_back(name);
    row_in.push_back(in);
    row_stall.push_back(st);
    row_flush.push_back(fl);
    row_model.push_back(use_model);
    row_exp.push_back(exp);
  endtask

  `include "vexec_vectors.svh"

  // a is vs2, b is vs1
  function automatic word_t alu_ref(aluop_t op, word_t a, word_t b);
    case (op)
      ADD: return a + b;
      SUB: return a - b;
      AND: return a & b;
      OR:  return a | b;
      XOR: return a ^ b;
      SLL: return a << b[4:0];
      SRL: return a >> b[4:0];
      MIN: return ($signed(a) < $signed(b)) ? a : b;
      MAX: return ($signed(a) > $signed(b)) ? a : b;
      default: return '0;
    endcase
  endfunction

  // Expected latch contents for ALU, mask and config rows
  function automatic ex_out_t rule_out(ex_in_t in);
    ex_out_t o;
    word_t   a0;
    word_t   a1;
    word_t   b0;
    word_t   b1;
    o = '0;
    b0 = (in.rs1_src == SRC_V) ? in.vs1_lane0 : (in.rs1_src == SRC_I) ? in.imm : in.xs1;
    b1 = (in.rs1_src == SRC_V) ? in.vs1_lane1 : (in.rs1_src == SRC_I) ? in.imm : in.xs1;
    a0 = (in.rs2_src == SRC_V) ? in.vs2_lane0 : (in.rs2_src == SRC_I) ? in.imm : in.xs2;
    a1 = (in.rs2_src == SRC_V) ? in.vs2_lane1 : (in.rs2_src == SRC_I) ? in.imm : in.xs2;
    if (in.fu == FU_ALU) begin
      o.aluresult0 = alu_ref(in.aluop, a0, b0);
      o.aluresult1 = alu_ref(in.aluop, a1, b1);
    end
    o.load = in.load;
    o.store = in.store;
    o.storedata0 = in.storedata0;
    o.storedata1 = in.storedata1;
    // Unmasked ops keep the input enables as they are
    o.wen = in.vm ? in.wen : (in.wen & {in.mask1, in.mask0});
    o.woffset0 = in.woffset0;
    o.woffset1 = in.woffset1;
    o.vd = in.vd;
    o.vl = in.vl;
    o.rd_sel = in.rd_sel;
    o.rd_wen = in.rd_wen | (in.fu == FU_CFG);
    o.rd_data = (in.fu == FU_CFG) ? word_t'(in.vl) : o.aluresult0;
    return o;
  endfunction

  task automatic check_value(string name, ex_out_t expected, ex_out_t actual);
    if (actual !== expected) begin
      fail_count++;
      $display("Error %s: expected %h, actual %h", name, expected, actual);
    end else begin
      pass_count++;
      $display("ok %s", name);
    end
  endtask

  // Every ALU op with each rs1 source, random operands
  task automatic build_alu_rows();
    ex_in_t r;
    aluop_t op;
    src_t   src;
    for (int i = 0; i < 9; i++) begin
      for (int j = 0; j < 3; j++) begin
        op = aluop_t'(i);
        src = src_t'(j);
        r = '0;
        r.fu = FU_ALU;
        r.aluop = op;
        r.rs1_src = src;
        r.rs2_src = src_t'((i + j) % 3);
        r.vs1_lane0 = $urandom();
        r.vs1_lane1 = $urandom();
        r.vs2_lane0 = $urandom();
        r.vs2_lane1 = $urandom();
        r.imm = $urandom();
        r.xs1 = $urandom();
        r.xs2 = $urandom();
        r.storedata0 = $urandom();
        r.storedata1 = $urandom();
        {r.rd_wen, r.vm, r.mask1, r.mask0, r.wen} = 6'($urandom());
        {r.vd, r.rd_sel, r.vl} = 16'($urandom());
        add_row($sformatf("alu_%s_rs1_%s", op.name(), src.name()), r, 1'b0, 1'b0, 1'b1, '0);
      end
    end
  endtask

  initial begin
    int n;
    ex_in <= '0;
    stall <= 1'b0;
    flush <= 1'b0;
    nRST <= 1'b0;
    void'($urandom(32'hda0d3caa));
    build_alu_rows();
    load_directed_rows();
    n = row_name.size();
    timeout_limit = n * 4 + 20;
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_value("after_reset", '0, ex_out);
    // Row i is driven on one edge and captured on the next
    for (int i = 0; i <= n; i++) begin
      @(posedge CLK);
      if (i < n) begin
        ex_in <= row_in[i];
        stall <= row_stall[i];
        flush <= row_flush[i];
      end else begin
        ex_in <= '0;
        stall <= 1'b0;
        flush <= 1'b0;
      end
      @(negedge CLK);
      if (i > 0) begin
        check_value(row_name[i-1], row_model[i-1] ? rule_out(row_in[i-1]) : row_exp[i-1],
                    ex_out);
      end
    end
    $display("Tests run: %0d, passed: %0d, failed: %0d",
             pass_count + fail_count, pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+verification
src/vexec_pkg.sv
src/vector_lane.sv
src/iota_logic.sv
src/vexec_execute_stage.sv
verification/vexec_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the vector execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module vexec_tb -o vexec_sim

output="$(./obj_dir/vexec_sim)"
echo "$output"

if echo "$output" | grep -qx "Finished with no errors"; then
  exit 0
else
  exit 1
fi
